//--- list.f
rx_bridge_pkg.sv
rx_tlp_decoder.sv
pending_rd_fifo.sv
cpl_buffer_ram.sv
rx_read_resp.sv
rx_bridge_top.sv
tb_rx_bridge.sv

//--- Bender.yml
package:
  name: rx_bridge

sources:
  - rx_bridge_pkg.sv
  - rx_tlp_decoder.sv
  - pending_rd_fifo.sv
  - cpl_buffer_ram.sv
  - rx_read_resp.sv
  - rx_bridge_top.sv
  - target: test
    files:
      - tb_rx_bridge.sv

//--- tb_rx_bridge.sv
/*
 * rx bridge testbench
 * directed tests for BAR 0 writes and reads, completion readout,
 * discarded packets and pending read FIFO throttling
 */
module tb_rx_bridge;
   import rx_bridge_pkg::*;

   localparam int        MAX_CYCLES = 4000;
   localparam avl_addr_t WIN_BASE   = 32'hA5B0_0000;

   logic         Clk_i;
   logic         Rstn_i;
   stream_data_t RxStData_i;
   logic         RxStSop_i;
   logic         RxStEop_i;
   logic         RxStValid_i;
   logic [7:0]   RxStBarDec_i;
   logic         RxStReady_o;
   logic         RxmWrite_o;
   logic         RxmRead_o;
   avl_addr_t    RxmAddress_o;
   stream_data_t RxmWriteData_o;
   avl_be_t      RxmByteEnable_o;
   burst_cnt_t   RxmBurstCount_o;
   logic         RxmWaitRequest_i;
   pndg_rd_hdr_t RxPndgRdFifoDat_o;
   logic         RxPndgRdFifoEmpty_o;
   logic         RxPndgRdFifoRdReq_i;
   stream_data_t TxReadData_o;
   logic         TxReadDataValid_o;
   logic         CplTagRelease_o;
   avl_addr_t    cb_p2a_avalon_addr_b0_i;

   integer       seed = 83218;
   int           err_cnt;
   int           chk_cnt;
   int           cycle_cnt;
   int           ready_waits;
   logic         stall_en;
   logic         stall_rnd;
   logic         stall_prev;
   avl_addr_t    addr_prev;
   burst_cnt_t   burst_prev;
   stream_data_t pay_q[$];
   stream_data_t wdat_q[$];
   avl_be_t      wbe_q[$];
   avl_addr_t    waddr_q[$];
   burst_cnt_t   wburst_q[$];
   avl_addr_t    raddr_q[$];
   burst_cnt_t   rburst_q[$];
   stream_data_t rdat_q[$];
   logic         rel_q[$];

   rx_bridge_top rx_bridge_top_i (.*);

   always #4 Clk_i = ~Clk_i;

   // random stalls on the Avalon side, drawn on the edge and driven just after
   always @(posedge Clk_i)
   begin
      stall_rnd = stall_en && (($random(seed) & 3) < 2);
      #1;
      RxmWaitRequest_i = stall_rnd;
   end

   always @(posedge Clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // Avalon and read data monitor, sampled mid cycle
   always @(negedge Clk_i)
   begin
      if (stall_prev)
      begin
         check_val("RxmWrite_o | RxmRead_o", 1, RxmWrite_o | RxmRead_o);
         check_val("RxmAddress_o", addr_prev, RxmAddress_o);
         check_val("RxmBurstCount_o", burst_prev, RxmBurstCount_o);
      end
      stall_prev = (RxmWrite_o | RxmRead_o) & RxmWaitRequest_i;
      addr_prev  = RxmAddress_o;
      burst_prev = RxmBurstCount_o;
      if (RxmWrite_o && !RxmWaitRequest_i)
      begin
         wdat_q.push_back(RxmWriteData_o);
         wbe_q.push_back(RxmByteEnable_o);
         waddr_q.push_back(RxmAddress_o);
         wburst_q.push_back(RxmBurstCount_o);
      end
      if (RxmRead_o && !RxmWaitRequest_i)
      begin
         raddr_q.push_back(RxmAddress_o);
         rburst_q.push_back(RxmBurstCount_o);
      end
      if (TxReadDataValid_o)
      begin
         rdat_q.push_back(TxReadData_o);
         rel_q.push_back(CplTagRelease_o);
      end
      else if (CplTagRelease_o)
      begin
         err_cnt++;
         $display("tag release pulsed without read data at %0t", $time);
      end
   end

   task automatic check_val(input string name, input logic [63:0] exp,
                            input logic [63:0] act);
      chk_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   // window base on top, PCIe address bits below
   function automatic avl_addr_t translate_addr(input avl_addr_t pcie);
      avl_addr_t mask;
      mask = (32'h1 << BAR0_WINDOW_BITS) - 1;
      return (WIN_BASE & ~mask) | (pcie & mask);
   endfunction

   task automatic send_beat(input stream_data_t dat, input logic sop, input logic eop,
                            input logic [7:0] bar);
      RxStData_i   = dat;
      RxStSop_i    = sop;
      RxStEop_i    = eop;
      RxStBarDec_i = bar;
      RxStValid_i  = 1'b1;
      @(negedge Clk_i);
      while (!RxStReady_o)
      begin
         ready_waits++;
         @(negedge Clk_i);
      end
      @(posedge Clk_i);
      #1;
      RxStValid_i = 1'b0;
      RxStSop_i   = 1'b0;
      RxStEop_i   = 1'b0;
   endtask

   // header beats, then whatever sits in pay_q
   task automatic send_tlp(input logic [31:0] dw0, input logic [31:0] dw1,
                           input logic [31:0] dw2, input logic [7:0] bar);
      send_beat({dw1, dw0}, 1'b1, 1'b0, bar);
      send_beat({$random(seed), dw2}, 1'b0, pay_q.size() == 0, bar);
      foreach (pay_q[i])
         send_beat(pay_q[i], 1'b0, i == pay_q.size() - 1, bar);
   endtask

   task automatic pop_fifo(output pndg_rd_hdr_t hdr);
      RxPndgRdFifoRdReq_i = 1'b1;
      @(posedge Clk_i);
      #1;
      RxPndgRdFifoRdReq_i = 1'b0;
      @(negedge Clk_i);
      hdr = RxPndgRdFifoDat_o;
      @(posedge Clk_i);
      #1;
   endtask

   task automatic reset_values();
      @(negedge Clk_i);
      check_val("RxmWrite_o", 0, RxmWrite_o);
      check_val("RxmRead_o", 0, RxmRead_o);
      check_val("TxReadDataValid_o", 0, TxReadDataValid_o);
      check_val("CplTagRelease_o", 0, CplTagRelease_o);
      check_val("RxPndgRdFifoEmpty_o", 1, RxPndgRdFifoEmpty_o);
      check_val("RxStReady_o", 1, RxStReady_o);
      @(posedge Clk_i);
      #1;
   endtask

   task automatic burst_write();
      avl_addr_t pcie_addr;
      pcie_addr = 32'h0001_2348;
      pay_q.delete();
      repeat (3)
         pay_q.push_back({$random(seed), $random(seed)});
      stall_en = 1'b1;
      send_tlp({TLP_MWR32, 14'h0, 10'd5}, 32'h0100_00FF, pcie_addr, 8'h01);
      while (wdat_q.size() < 3)
         @(negedge Clk_i);
      stall_en = 1'b0;
      // 5 doublewords give 3 beats, the last one half full
      foreach (pay_q[i])
      begin
         check_val("RxmAddress_o", translate_addr(pcie_addr), waddr_q[i]);
         check_val("RxmBurstCount_o", 3, wburst_q[i]);
         check_val("RxmWriteData_o", pay_q[i], wdat_q[i]);
         check_val("RxmByteEnable_o", (i == 2) ? 8'h0F : 8'hFF, wbe_q[i]);
      end
      pay_q.delete();
      repeat (4)
         @(negedge Clk_i);
      check_val("Avalon write count", 3, wdat_q.size());
      @(posedge Clk_i);
      #1;
   endtask

   task automatic single_read();
      pndg_rd_hdr_t hdr;
      stall_en = 1'b1;
      send_tlp({TLP_MRD32, 14'h0, 10'd7}, {16'hBEEF, 8'h3C, 8'h0F}, 32'h0004_5A64, 8'h01);
      while (raddr_q.size() < 1)
         @(negedge Clk_i);
      stall_en = 1'b0;
      check_val("RxmAddress_o", translate_addr(32'h0004_5A64), raddr_q[0]);
      check_val("RxmBurstCount_o", 4, rburst_q[0]);
      while (RxPndgRdFifoEmpty_o)
         @(negedge Clk_i);
      @(posedge Clk_i);
      #1;
      pop_fifo(hdr);
      check_val("RxPndgRdFifoDat_o", {16'hBEEF, 8'h3C, 10'd7, 7'h64}, hdr);
      check_val("RxPndgRdFifoEmpty_o", 1, RxPndgRdFifoEmpty_o);
      check_val("Avalon read count", 1, raddr_q.size());
   endtask

   task automatic completion_readout();
      stream_data_t exp_q[$];
      rdat_q.delete();
      rel_q.delete();
      repeat (3)
         pay_q.push_back({$random(seed), $random(seed)});
      exp_q = pay_q;
      send_tlp({TLP_CPLD, 14'h0, 10'd6}, 32'h0100_0018, {16'h0, 8'h02, 8'h00}, 8'h00);
      pay_q.delete();
      pay_q.push_back({$random(seed), $random(seed)});
      exp_q.push_back(pay_q[0]);
      send_tlp({TLP_CPLD, 14'h0, 10'd2}, 32'h0100_0008, {16'h0, 8'h05, 8'h00}, 8'h00);
      pay_q.delete();
      while (rdat_q.size() < 4)
         @(negedge Clk_i);
      // leave room for any stray beat
      repeat (20)
         @(negedge Clk_i);
      check_val("read data beat count", 4, rdat_q.size());
      foreach (exp_q[i])
      begin
         check_val("TxReadData_o", exp_q[i], rdat_q[i]);
         check_val("CplTagRelease_o", (i == 2 || i == 3), rel_q[i]);
      end
      @(posedge Clk_i);
      #1;
   endtask

   task automatic discard_packets();
      int waits0;
      waits0 = ready_waits;
      wdat_q.delete();
      raddr_q.delete();
      rdat_q.delete();
      pay_q.push_back({$random(seed), $random(seed)});
      pay_q.push_back({$random(seed), $random(seed)});
      // only BAR 1 hit
      send_tlp({TLP_MWR32, 14'h0, 10'd4}, 32'h0100_000F, 32'h0000_1000, 8'h02);
      pay_q.delete();
      pay_q.push_back({$random(seed), $random(seed)});
      // configuration write type
      send_tlp({8'h44, 14'h0, 10'd1}, 32'h0100_000F, 32'h0000_0010, 8'h01);
      pay_q.delete();
      repeat (20)
         @(negedge Clk_i);
      check_val("stream stall cycles", 0, ready_waits - waits0);
      check_val("Avalon write count", 0, wdat_q.size());
      check_val("Avalon read count", 0, raddr_q.size());
      check_val("read data beat count", 0, rdat_q.size());
      @(posedge Clk_i);
      #1;
   endtask

   task automatic fifo_throttle();
      pndg_rd_hdr_t hdr;
      for (int i = 0; i < PNDG_FIFO_HIGH; i++)
         send_tlp({TLP_MRD32, 14'h0, 10'd2}, {16'h0200, 8'(i), 8'hFF},
                  32'h0000_2000 + 32'(i * 8), 8'h01);
      while (raddr_q.size() < PNDG_FIFO_HIGH)
         @(negedge Clk_i);
      @(posedge Clk_i);
      #1;
      fork
         send_tlp({TLP_MRD32, 14'h0, 10'd2}, {16'h0200, 8'h40, 8'hFF}, 32'h0000_3000, 8'h01);
         begin
            repeat (8)
            begin
               @(negedge Clk_i);
               check_val("RxStReady_o", 0, RxStReady_o);
            end
            @(posedge Clk_i);
            #1;
            pop_fifo(hdr);
            check_val("RxPndgRdFifoDat_o", {16'h0200, 8'h00, 10'd2, 7'h00}, hdr);
         end
      join
      while (raddr_q.size() < PNDG_FIFO_HIGH + 1)
         @(negedge Clk_i);
      check_val("RxmAddress_o", translate_addr(32'h0000_3000), raddr_q[PNDG_FIFO_HIGH]);
      @(posedge Clk_i);
      #1;
   endtask

   initial
   begin
      Clk_i                   = 1'b0;
      Rstn_i                  = 1'b0;
      RxStData_i              = '0;
      RxStSop_i               = 1'b0;
      RxStEop_i               = 1'b0;
      RxStValid_i             = 1'b0;
      RxStBarDec_i            = '0;
      RxmWaitRequest_i        = 1'b0;
      RxPndgRdFifoRdReq_i     = 1'b0;
      cb_p2a_avalon_addr_b0_i = WIN_BASE;
      stall_en                = 1'b0;
      stall_prev              = 1'b0;
      repeat (2)
         @(posedge Clk_i);
      #1;
      Rstn_i = 1'b1;
      reset_values();
      burst_write();
      single_read();
      completion_readout();
      discard_packets();
      fifo_throttle();
      $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- rx_bridge_top.sv
/*
 * rx bridge top
 * receive side of the PCIe to Avalon bridge: packet decoder,
 * pending read FIFO, completion buffer and read response unit
 */
module rx_bridge_top (
   input  logic                         Clk_i,
   input  logic                         Rstn_i,
   input  rx_bridge_pkg::stream_data_t  RxStData_i,
   input  logic                         RxStSop_i,
   input  logic                         RxStEop_i,
   input  logic                         RxStValid_i,
   input  logic [7:0]                   RxStBarDec_i,
   output logic                         RxStReady_o,
   output logic                         RxmWrite_o,
   output logic                         RxmRead_o,
   output rx_bridge_pkg::avl_addr_t     RxmAddress_o,
   output rx_bridge_pkg::stream_data_t  RxmWriteData_o,
   output rx_bridge_pkg::avl_be_t       RxmByteEnable_o,
   output rx_bridge_pkg::burst_cnt_t    RxmBurstCount_o,
   input  logic                         RxmWaitRequest_i,
   output rx_bridge_pkg::pndg_rd_hdr_t  RxPndgRdFifoDat_o,
   output logic                         RxPndgRdFifoEmpty_o,
   input  logic                         RxPndgRdFifoRdReq_i,
   output rx_bridge_pkg::stream_data_t  TxReadData_o,
   output logic                         TxReadDataValid_o,
   output logic                         CplTagRelease_o,
   input  rx_bridge_pkg::avl_addr_t     cb_p2a_avalon_addr_b0_i
);
   import rx_bridge_pkg::*;

   logic                   pndg_wr_req;
   pndg_rd_hdr_t           pndg_hdr;
   logic [PNDG_USED_W-1:0] pndg_used_w;
   logic                   cplram_wr_ena;
   cpl_ram_addr_t          cplram_wr_addr;
   cpl_ram_word_t          cplram_wr_dat;
   cpl_ram_addr_t          cplram_rd_addr;
   cpl_ram_word_t          cplram_rd_dat;
   logic                   cpl_req;
   cpl_tag_t               cpl_tag;

   rx_tlp_decoder rx_tlp_decoder_i (
      .Clk_i                   (Clk_i),
      .Rstn_i                  (Rstn_i),
      .RxStData_i              (RxStData_i),
      .RxStSop_i               (RxStSop_i),
      .RxStEop_i               (RxStEop_i),
      .RxStValid_i             (RxStValid_i),
      .RxStBarDec_i            (RxStBarDec_i),
      .RxStReady_o             (RxStReady_o),
      .RxmWrite_o              (RxmWrite_o),
      .RxmRead_o               (RxmRead_o),
      .RxmAddress_o            (RxmAddress_o),
      .RxmWriteData_o          (RxmWriteData_o),
      .RxmByteEnable_o         (RxmByteEnable_o),
      .RxmBurstCount_o         (RxmBurstCount_o),
      .RxmWaitRequest_i        (RxmWaitRequest_i),
      .cb_p2a_avalon_addr_b0_i (cb_p2a_avalon_addr_b0_i),
      .pndg_used_w_i           (pndg_used_w),
      .pndg_wr_req_o           (pndg_wr_req),
      .pndg_hdr_o              (pndg_hdr),
      .cplram_wr_ena_o         (cplram_wr_ena),
      .cplram_wr_addr_o        (cplram_wr_addr),
      .cplram_wr_dat_o         (cplram_wr_dat),
      .cpl_req_o               (cpl_req),
      .cpl_tag_o               (cpl_tag)
   );

   pending_rd_fifo pending_rd_fifo_i (
      .Clk_i    (Clk_i),
      .Rstn_i   (Rstn_i),
      .wr_req_i (pndg_wr_req),
      .wr_dat_i (pndg_hdr),
      .rd_req_i (RxPndgRdFifoRdReq_i),
      .rd_dat_o (RxPndgRdFifoDat_o),
      .empty_o  (RxPndgRdFifoEmpty_o),
      .used_w_o (pndg_used_w)
   );

   cpl_buffer_ram cpl_buffer_ram_i (
      .Clk_i     (Clk_i),
      .wr_ena_i  (cplram_wr_ena),
      .wr_addr_i (cplram_wr_addr),
      .wr_dat_i  (cplram_wr_dat),
      .rd_addr_i (cplram_rd_addr),
      .rd_dat_o  (cplram_rd_dat)
   );

   rx_read_resp rx_read_resp_i (
      .Clk_i             (Clk_i),
      .Rstn_i            (Rstn_i),
      .cpl_req_i         (cpl_req),
      .cpl_tag_i         (cpl_tag),
      .cplram_rd_dat_i   (cplram_rd_dat),
      .cplram_rd_addr_o  (cplram_rd_addr),
      .TxReadData_o      (TxReadData_o),
      .TxReadDataValid_o (TxReadDataValid_o),
      .CplTagRelease_o   (CplTagRelease_o)
   );

endmodule

//--- rx_read_resp.sv
/*
 * read response unit
 * queues completed tags, streams each tag region out of the
 * completion buffer and releases the tag with its last word
 */
module rx_read_resp (
   input  logic                         Clk_i,
   input  logic                         Rstn_i,
   input  logic                         cpl_req_i,
   input  rx_bridge_pkg::cpl_tag_t      cpl_tag_i,
   input  rx_bridge_pkg::cpl_ram_word_t cplram_rd_dat_i,
   output rx_bridge_pkg::cpl_ram_addr_t cplram_rd_addr_o,
   output rx_bridge_pkg::stream_data_t  TxReadData_o,
   output logic                         TxReadDataValid_o,
   output logic                         CplTagRelease_o
);
   import rx_bridge_pkg::*;

   cpl_tag_t             tag_q [NUM_TAGS];
   logic [TAG_PTR_W-1:0] wr_ptr_q;
   logic [TAG_PTR_W-1:0] rd_ptr_q;
   logic [TAG_PTR_W:0]   count_q;
   logic [CPL_OFF_W-1:0] off_q;
   logic                 valid_q;
   logic                 last_beat;
   logic                 issue;

   assign last_beat = valid_q & cplram_rd_dat_i[CPL_LAST_BIT];
   // the read issued alongside the last word is dropped
   assign issue     = (count_q != '0) & ~last_beat;

   assign cplram_rd_addr_o  = {tag_q[rd_ptr_q], off_q};
   assign TxReadData_o      = cplram_rd_dat_i[CPL_LAST_BIT-1:0];
   assign TxReadDataValid_o = valid_q;
   assign CplTagRelease_o   = last_beat;

   always_ff @(posedge Clk_i)
   begin
      if (cpl_req_i)
         tag_q[wr_ptr_q] <= cpl_tag_i;
   end

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         off_q    <= '0;
         valid_q  <= 1'b0;
      end
      else
      begin
         if (cpl_req_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (last_beat)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_q + (TAG_PTR_W+1)'(cpl_req_i) - (TAG_PTR_W+1)'(last_beat);
         // valid trails the read by one cycle to meet the RAM data
         valid_q <= issue;
         if (last_beat)
            off_q <= '0;
         else if (issue)
            off_q <= off_q + 1'b1;
      end
   end

   // each tag carries one completion, so the decoder never has more than eight
   a_no_queue_overflow: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      cpl_req_i |-> (count_q < (TAG_PTR_W+1)'(NUM_TAGS)));

endmodule

//--- cpl_buffer_ram.sv
/*
 * completion buffer RAM
 * one 64-word region per tag, registered read address
 */
module cpl_buffer_ram (
   input  logic                         Clk_i,
   input  logic                         wr_ena_i,
   input  rx_bridge_pkg::cpl_ram_addr_t wr_addr_i,
   input  rx_bridge_pkg::cpl_ram_word_t wr_dat_i,
   input  rx_bridge_pkg::cpl_ram_addr_t rd_addr_i,
   output rx_bridge_pkg::cpl_ram_word_t rd_dat_o
);
   import rx_bridge_pkg::*;

   cpl_ram_word_t mem_q [NUM_TAGS*CPL_WORDS_PER_TAG];
   cpl_ram_addr_t rd_addr_q;

   always_ff @(posedge Clk_i)
   begin
      if (wr_ena_i)
         mem_q[wr_addr_i] <= wr_dat_i;
      rd_addr_q <= rd_addr_i;
   end

   // unregistered output, data one cycle after the address
   assign rd_dat_o = mem_q[rd_addr_q];

endmodule

//--- pending_rd_fifo.sv
/*
 * pending read FIFO
 * 16 read headers waiting for the transmit side, registered output
 */
module pending_rd_fifo (
   input  logic                                  Clk_i,
   input  logic                                  Rstn_i,
   input  logic                                  wr_req_i,
   input  rx_bridge_pkg::pndg_rd_hdr_t           wr_dat_i,
   input  logic                                  rd_req_i,
   output rx_bridge_pkg::pndg_rd_hdr_t           rd_dat_o,
   output logic                                  empty_o,
   output logic [rx_bridge_pkg::PNDG_USED_W-1:0] used_w_o
);
   import rx_bridge_pkg::*;

   pndg_rd_hdr_t          mem_q [PNDG_FIFO_DEPTH];
   logic [PNDG_PTR_W-1:0] wr_ptr_q;
   logic [PNDG_PTR_W-1:0] rd_ptr_q;
   logic                  full;

   assign full    = (used_w_o == PNDG_USED_W'(PNDG_FIFO_DEPTH));
   assign empty_o = (used_w_o == '0);

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         used_w_o <= '0;
      end
      else
      begin
         if (wr_req_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_req_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         used_w_o <= used_w_o + PNDG_USED_W'(wr_req_i) - PNDG_USED_W'(rd_req_i);
      end
   end

   // data appears the cycle after the pop
   always_ff @(posedge Clk_i)
   begin
      if (wr_req_i)
         mem_q[wr_ptr_q] <= wr_dat_i;
      if (rd_req_i)
         rd_dat_o <= mem_q[rd_ptr_q];
   end

   // decoder throttles at the high mark, transmit side pops only when not empty
   a_no_overflow: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      wr_req_i |-> !full);

   a_no_underflow: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      rd_req_i |-> !empty_o);

endmodule

//--- rx_tlp_decoder.sv
/*
 * rx packet decoder
 * classifies incoming packets, drives the Avalon master for BAR 0
 * writes and reads, queues read headers and stores completion data
 */
module rx_tlp_decoder (
   input  logic                                  Clk_i,
   input  logic                                  Rstn_i,
   input  rx_bridge_pkg::stream_data_t           RxStData_i,
   input  logic                                  RxStSop_i,
   input  logic                                  RxStEop_i,
   input  logic                                  RxStValid_i,
   input  logic [7:0]                            RxStBarDec_i,
   output logic                                  RxStReady_o,
   output logic                                  RxmWrite_o,
   output logic                                  RxmRead_o,
   output rx_bridge_pkg::avl_addr_t              RxmAddress_o,
   output rx_bridge_pkg::stream_data_t           RxmWriteData_o,
   output rx_bridge_pkg::avl_be_t                RxmByteEnable_o,
   output rx_bridge_pkg::burst_cnt_t             RxmBurstCount_o,
   input  logic                                  RxmWaitRequest_i,
   input  rx_bridge_pkg::avl_addr_t              cb_p2a_avalon_addr_b0_i,
   input  logic [rx_bridge_pkg::PNDG_USED_W-1:0] pndg_used_w_i,
   output logic                                  pndg_wr_req_o,
   output rx_bridge_pkg::pndg_rd_hdr_t           pndg_hdr_o,
   output logic                                  cplram_wr_ena_o,
   output rx_bridge_pkg::cpl_ram_addr_t          cplram_wr_addr_o,
   output rx_bridge_pkg::cpl_ram_word_t          cplram_wr_dat_o,
   output logic                                  cpl_req_o,
   output rx_bridge_pkg::cpl_tag_t               cpl_tag_o
);
   import rx_bridge_pkg::*;

   rx_state_e            state_q;
   rx_state_e            state_d;
   logic [31:0]          dw0_q;
   logic [31:0]          dw1_q;
   logic                 bar0_hit_q;
   tlp_len_t             dw_left_q;
   cpl_tag_t             tag_q;
   logic [CPL_OFF_W-1:0] cpl_off_q;
   logic                 take;
   logic                 wr_hold;
   logic                 last_pay;
   logic [7:0]           fmt_type;
   tlp_len_t             hdr_len;
   logic [10:0]          len_plus1;

   assign take      = RxStValid_i & RxStReady_o;
   // write beat still waiting on the Avalon side
   assign wr_hold   = RxmWrite_o & RxmWaitRequest_i;
   assign fmt_type  = dw0_q[31:24];
   assign hdr_len   = dw0_q[9:0];
   assign len_plus1 = {1'b0, hdr_len} + 11'd1;
   // at most two doublewords left means this beat closes the payload
   assign last_pay  = (dw_left_q <= tlp_len_t'(2));

   assign RxmRead_o     = (state_q == RX_RD_ISSUE);
   assign pndg_wr_req_o = RxmRead_o & ~RxmWaitRequest_i;

   always_comb
   begin
      case (state_q)
         RX_IDLE:             RxStReady_o = (pndg_used_w_i < PNDG_USED_W'(PNDG_FIFO_HIGH));
         RX_HDR2, RX_WR_DATA: RxStReady_o = ~wr_hold;
         RX_RD_ISSUE:         RxStReady_o = 1'b0;
         default:             RxStReady_o = 1'b1;
      endcase
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         RX_IDLE:
            if (take && RxStSop_i)
               state_d = RX_HDR2;
         RX_HDR2:
            if (take)
            begin
               if (bar0_hit_q && fmt_type == TLP_MWR32)
                  state_d = RX_WR_DATA;
               else if (bar0_hit_q && fmt_type == TLP_MRD32)
                  state_d = RX_RD_ISSUE;
               else if (fmt_type == TLP_CPLD)
                  state_d = RX_CPL_DATA;
               else if (RxStEop_i)
                  state_d = RX_IDLE;
               else
                  state_d = RX_DISCARD;
            end
         RX_WR_DATA, RX_CPL_DATA:
            if (take && last_pay)
               state_d = RX_IDLE;
         RX_RD_ISSUE:
            if (!RxmWaitRequest_i)
               state_d = RX_IDLE;
         RX_DISCARD:
            if (take && RxStEop_i)
               state_d = RX_IDLE;
         default:
            state_d = RX_IDLE;
      endcase
   end

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         state_q         <= RX_IDLE;
         RxmWrite_o      <= 1'b0;
         cplram_wr_ena_o <= 1'b0;
         cpl_req_o       <= 1'b0;
         dw_left_q       <= '0;
         cpl_off_q       <= '0;
      end
      else
      begin
         state_q         <= state_d;
         cplram_wr_ena_o <= take & (state_q == RX_CPL_DATA);
         // tag is complete once its last word sits in the RAM
         cpl_req_o       <= cplram_wr_ena_o & cplram_wr_dat_o[CPL_LAST_BIT];
         if (take && state_q == RX_WR_DATA)
            RxmWrite_o <= 1'b1;
         else if (!RxmWaitRequest_i)
            RxmWrite_o <= 1'b0;
         if (take && state_q == RX_HDR2)
         begin
            dw_left_q <= hdr_len;
            cpl_off_q <= '0;
         end
         else if (take && (state_q == RX_WR_DATA || state_q == RX_CPL_DATA))
         begin
            dw_left_q <= dw_left_q - tlp_len_t'(2);
            cpl_off_q <= cpl_off_q + 1'b1;
         end
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (take && state_q == RX_IDLE)
      begin
         dw0_q      <= RxStData_i[31:0];
         dw1_q      <= RxStData_i[63:32];
         bar0_hit_q <= RxStBarDec_i[BAR0_HIT_BIT];
      end
      if (take && state_q == RX_HDR2)
      begin
         // DW2 carries the request address or the completion tag
         RxmAddress_o    <= {cb_p2a_avalon_addr_b0_i[31:BAR0_WINDOW_BITS],
                             RxStData_i[BAR0_WINDOW_BITS-1:0]};
         RxmBurstCount_o <= burst_cnt_t'(len_plus1 >> 1);
         pndg_hdr_o      <= {dw1_q[31:16], dw1_q[15:8], hdr_len, RxStData_i[6:0]};
         tag_q           <= RxStData_i[8 +: TAG_PTR_W];
      end
      if (take && state_q == RX_WR_DATA)
      begin
         RxmWriteData_o  <= RxStData_i;
         RxmByteEnable_o <= (dw_left_q == tlp_len_t'(1)) ? 8'h0F : 8'hFF;
      end
      if (take && state_q == RX_CPL_DATA)
      begin
         cplram_wr_addr_o <= {tag_q, cpl_off_q};
         cplram_wr_dat_o  <= {last_pay, RxStData_i};
      end
      if (cplram_wr_ena_o)
         cpl_tag_o <= cplram_wr_addr_o[CPL_OFF_W +: TAG_PTR_W];
   end

   // one master port, so a read never overlaps a pending write
   a_no_wr_rd: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      !(RxmWrite_o && RxmRead_o));

   a_sop_in_idle: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      (take && RxStSop_i) |-> (state_q == RX_IDLE));

endmodule

//--- rx_bridge_pkg.sv
/*
 * rx bridge package
 * packet format constants, widths, types and the decoder states
 * shared by the receive side of the PCIe to Avalon bridge
 */
package rx_bridge_pkg;

   // stream beat, also one Avalon data word
   typedef logic [63:0] stream_data_t;
   typedef logic [31:0] avl_addr_t;
   typedef logic [7:0]  avl_be_t;
   typedef logic [6:0]  burst_cnt_t;
   typedef logic [9:0]  tlp_len_t;

   localparam int NUM_TAGS          = 8;
   localparam int CPL_WORDS_PER_TAG = 64;
   localparam int TAG_PTR_W         = $clog2(NUM_TAGS);
   localparam int CPL_OFF_W         = $clog2(CPL_WORDS_PER_TAG);
   localparam int CPL_LAST_BIT      = $bits(stream_data_t);

   typedef logic [TAG_PTR_W-1:0] cpl_tag_t;

   // tag in the upper bits, word offset below
   typedef logic [TAG_PTR_W+CPL_OFF_W-1:0] cpl_ram_addr_t;

   // last flag on top of the data word
   typedef logic [CPL_LAST_BIT:0] cpl_ram_word_t;

   // requester id (16), tag (8), length (10), low address (7)
   typedef logic [40:0] pndg_rd_hdr_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_HDR2,
      RX_WR_DATA,
      RX_RD_ISSUE,
      RX_CPL_DATA,
      RX_DISCARD
   } rx_state_e;

   // format and type byte of DW0
   localparam logic [7:0] TLP_MWR32 = 8'h40;
   localparam logic [7:0] TLP_MRD32 = 8'h00;
   localparam logic [7:0] TLP_CPLD  = 8'h4A;

   localparam int BAR0_HIT_BIT     = 0;
   localparam int BAR0_WINDOW_BITS = 20;

   localparam int PNDG_FIFO_DEPTH = 16;
   localparam int PNDG_FIFO_HIGH  = 14;
   localparam int PNDG_PTR_W      = $clog2(PNDG_FIFO_DEPTH);
   localparam int PNDG_USED_W     = PNDG_PTR_W + 1;

endpackage
